// ==== common/axi_read_pkg.sv ====
package axi_read_pkg;

   localparam int AXI_LEN_W = 8;

   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

   // Modifiable, non-bufferable
   localparam logic [3:0] AXI_CACHE_DEFAULT = 4'b0010;

   // Unprivileged, non-secure, data access
   localparam logic [2:0] AXI_PROT_DEFAULT = 3'b010;

   localparam int BOUNDARY_W = 12;   // 4 KB page
   localparam int MAX_BEATS  = 256;

   // arsize encoding for a full-width beat
   function automatic logic [2:0] axi_size_code(input int data_w);
      case (data_w)
         16:      return 3'b001;
         32:      return 3'b010;
         64:      return 3'b011;
         128:     return 3'b100;
         256:     return 3'b101;
         512:     return 3'b110;
         1024:    return 3'b111;
         default: return 3'b000;
      endcase
   endfunction

   function automatic int offset_w(input int data_w);
      return $clog2(data_w / 8);   // Byte lane select bits
   endfunction

endpackage

// ==== common/burst_cmd_if.sv ====
`timescale 1ns/1ps

interface burst_cmd_if
   import axi_read_pkg::*;
#(
   parameter int AXI_ADDR_W = 32
) ();
   logic                  start;       // Load a new request
   logic                  next;        // Step to following burst, at AR handshake
   logic [AXI_ADDR_W-1:0] axaddr;
   logic [AXI_LEN_W-1:0]  axlen;       // Beats minus one
   logic                  last_burst;

   modport splitter (
      input  start, next,
      output axaddr, axlen, last_burst
   );

   modport sequencer (
      output start, next,
      input  axlen, last_burst
   );
endinterface

// ==== simple_axi_read/burst_splitter.sv ====
`timescale 1ns/1ps

module burst_splitter
   import axi_read_pkg::*;
#(
   parameter int AXI_ADDR_W = 32,
   parameter int AXI_DATA_W = 32,
   parameter int LEN_W      = 12
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic [AXI_ADDR_W-1:0] req_addr_i,
   input  logic [LEN_W-1:0]      req_len_i,
   burst_cmd_if.splitter         cmd
);
   localparam int OFF_W  = offset_w(AXI_DATA_W);
   localparam int BYTES  = AXI_DATA_W / 8;
   localparam int CNT_W  = LEN_W + 1;
   localparam int PAGE_W = BOUNDARY_W + 1;
   localparam int CMP_W  = (CNT_W > PAGE_W) ? CNT_W : PAGE_W;

   logic [AXI_ADDR_W-1:0] src_addr;      // Address of the burst being formed
   logic [CMP_W-1:0]      src_beats;     // Beats still to issue, this burst included
   logic [CMP_W-1:0]      page_beats;
   logic [CMP_W-1:0]      burst_beats;
   logic [CMP_W-1:0]      rem_beats_q;   // Beats left after the presented burst

   always_comb begin
      if (cmd.start) begin
         // Beats cover the leading offset plus the length, rounded up
         src_addr  = {req_addr_i[AXI_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
         src_beats = CMP_W'((CNT_W'(req_addr_i[OFF_W-1:0]) + CNT_W'(req_len_i)
                             + CNT_W'(BYTES - 1)) >> OFF_W);
      end else begin
         src_addr  = cmd.axaddr + ((AXI_ADDR_W'(cmd.axlen) + 1'b1) << OFF_W);
         src_beats = rem_beats_q;
      end

      // Beats until the next 4 KB page
      page_beats = CMP_W'(({1'b1, {BOUNDARY_W{1'b0}}}
                           - {1'b0, src_addr[BOUNDARY_W-1:0]}) >> OFF_W);

      burst_beats = src_beats;
      if (page_beats < burst_beats) begin
         burst_beats = page_beats;
      end
      if (CMP_W'(MAX_BEATS) < burst_beats) begin
         burst_beats = CMP_W'(MAX_BEATS);
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         rem_beats_q    <= '0;
         cmd.last_burst <= 1'b0;
      end else if (cmd.start || cmd.next) begin
         rem_beats_q    <= src_beats - burst_beats;
         cmd.last_burst <= (src_beats == burst_beats);
      end
   end

   // Burst fields, stable between start/next pulses
   always_ff @(posedge clk_i) begin
      if (cmd.start || cmd.next) begin
         cmd.axaddr <= src_addr;
         cmd.axlen  <= AXI_LEN_W'(burst_beats - 1'b1);
      end
   end

endmodule

// ==== simple_axi_read/read_sequencer.sv ====
`timescale 1ns/1ps

module read_sequencer
   import axi_read_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 req_valid_i,
   output logic                 req_ready_o,
   burst_cmd_if.sequencer       cmd,
   input  logic                 aligner_empty_i,
   output logic                 axi_arvalid_o,
   output logic [AXI_LEN_W-1:0] axi_arlen_o,
   input  logic                 axi_arready_i,
   input  logic                 axi_rvalid_i,
   input  logic                 axi_rlast_i,
   output logic                 axi_rready_o,
   output logic                 burst_done_o
);
   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_LOAD = 2'd1;
   localparam logic [1:0] ST_ADDR = 2'd2;
   localparam logic [1:0] ST_DATA = 2'd3;

   logic [1:0] state;
   logic       last_q;        // Issued burst ends the request
   logic       r_last_beat;

   assign req_ready_o  = (state == ST_IDLE) && aligner_empty_i;
   assign cmd.start    = req_valid_i && req_ready_o;
   assign cmd.next     = axi_arvalid_o && axi_arready_i;
   assign axi_rready_o = (state == ST_DATA);
   assign r_last_beat  = axi_rvalid_i && axi_rready_o && axi_rlast_i;
   assign burst_done_o = r_last_beat && last_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state         <= ST_IDLE;
         axi_arvalid_o <= 1'b0;
         last_q        <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (cmd.start) state <= ST_LOAD;
            end
            ST_LOAD: begin
               axi_arvalid_o <= 1'b1;
               last_q        <= cmd.last_burst;   // Splitter moves on at AR handshake
               state         <= ST_ADDR;
            end
            ST_ADDR: begin
               if (axi_arready_i) begin
                  axi_arvalid_o <= 1'b0;
                  state         <= ST_DATA;
               end
            end
            default: begin
               if (r_last_beat) state <= last_q ? ST_IDLE : ST_LOAD;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state == ST_LOAD) axi_arlen_o <= cmd.axlen;
   end

endmodule

// ==== simple_axi_read/read_aligner.sv ====
`timescale 1ns/1ps

module read_aligner
   import axi_read_pkg::*;
#(
   parameter int AXI_DATA_W = 32,
   parameter int LEN_W      = 12
) (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic [offset_w(AXI_DATA_W)-1:0] offset_i,
   input  logic [LEN_W-1:0]                len_i,
   input  logic                            start_i,
   input  logic [AXI_DATA_W-1:0]           beat_data_i,
   input  logic                            beat_valid_i,
   input  logic                            burst_done_i,
   output logic [AXI_DATA_W-1:0]           rdata_o,
   output logic                            rvalid_o,
   output logic                            rlast_o,
   output logic                            empty_o
);
   localparam int OFF_W = offset_w(AXI_DATA_W);
   localparam int BYTES = AXI_DATA_W / 8;
   localparam int CNT_W = LEN_W + 1;

   logic [OFF_W+2:0]      shift_bits;   // Offset in bits
   logic [OFF_W+3:0]      up_bits;
   logic [AXI_DATA_W-1:0] merged;
   logic [AXI_DATA_W-1:0] held_q;
   logic                  held_valid;
   logic [CNT_W-1:0]      req_words;
   logic [CNT_W-1:0]      owed_q;       // Output words still owed
   logic [CNT_W-1:0]      owed_after;
   logic                  emit_beat;
   logic                  flush_q;

   assign shift_bits = {offset_i, 3'b000};
   assign up_bits    = (OFF_W + 4)'(AXI_DATA_W) - (OFF_W + 4)'(shift_bits);

   // Upper bytes of held beat in low lanes, low bytes of new beat above them
   assign merged = (held_q >> shift_bits) | (beat_data_i << up_bits);

   assign req_words = (CNT_W'(len_i) + CNT_W'(BYTES - 1)) >> OFF_W;

   // Aligned stream passes straight through, otherwise wait for a held beat
   assign emit_beat  = beat_valid_i && (owed_q != '0)
                       && ((offset_i == '0) || held_valid);
   assign owed_after = emit_beat ? owed_q - 1'b1 : owed_q;

   assign empty_o = (owed_q == '0) && !held_valid && !flush_q && !rvalid_o;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         held_valid <= 1'b0;
         owed_q     <= '0;
         flush_q    <= 1'b0;
         rvalid_o   <= 1'b0;
         rlast_o    <= 1'b0;
      end else begin
         rvalid_o <= emit_beat || flush_q;
         rlast_o  <= (emit_beat || flush_q) && (owed_q == CNT_W'(1));
         if (start_i) begin
            owed_q     <= req_words;
            held_valid <= 1'b0;
            flush_q    <= 1'b0;
         end else if (flush_q) begin
            owed_q     <= '0;   // Flush is always the final word
            held_valid <= 1'b0;
            flush_q    <= 1'b0;
         end else if (beat_valid_i) begin
            owed_q     <= owed_after;
            held_valid <= !burst_done_i;
            flush_q    <= burst_done_i && (owed_after != '0);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (beat_valid_i) held_q <= beat_data_i;
      if (flush_q) begin
         rdata_o <= held_q >> shift_bits;   // Upper lanes don't care
      end else if (emit_beat) begin
         rdata_o <= (offset_i == '0) ? beat_data_i : merged;
      end
   end

endmodule

// ==== simple_axi_read/simple_axi_read.sv ====
`timescale 1ns/1ps

module simple_axi_read
   import axi_read_pkg::*;
#(
   parameter int AXI_ADDR_W = 32,
   parameter int AXI_DATA_W = 32,
   parameter int LEN_W      = 12
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   // Request
   input  logic                  req_valid_i,
   output logic                  req_ready_o,
   input  logic [AXI_ADDR_W-1:0] req_addr_i,
   input  logic [LEN_W-1:0]      req_len_i,
   // Output stream, no back-pressure
   output logic [AXI_DATA_W-1:0] rdata_o,
   output logic                  rvalid_o,
   output logic                  rlast_o,
   // AXI read address
   output logic [AXI_ADDR_W-1:0] axi_araddr_o,
   output logic [AXI_LEN_W-1:0]  axi_arlen_o,
   output logic [2:0]            axi_arsize_o,
   output logic [1:0]            axi_arburst_o,
   output logic [3:0]            axi_arcache_o,
   output logic [2:0]            axi_arprot_o,
   output logic                  axi_arvalid_o,
   input  logic                  axi_arready_i,
   // AXI read data
   input  logic [AXI_DATA_W-1:0] axi_rdata_i,
   input  logic                  axi_rlast_i,
   input  logic                  axi_rvalid_i,
   output logic                  axi_rready_o
);
   localparam int OFF_W = offset_w(AXI_DATA_W);

   logic aligner_empty;
   logic burst_done;
   logic rbeat_valid;

   burst_cmd_if #(.AXI_ADDR_W(AXI_ADDR_W)) cmd_if ();

   assign axi_araddr_o  = cmd_if.axaddr;
   assign axi_arsize_o  = axi_size_code(AXI_DATA_W);
   assign axi_arburst_o = AXI_BURST_INCR;
   assign axi_arcache_o = AXI_CACHE_DEFAULT;
   assign axi_arprot_o  = AXI_PROT_DEFAULT;
   assign rbeat_valid   = axi_rvalid_i && axi_rready_o;   // Accepted R beat

   burst_splitter #(
      .AXI_ADDR_W (AXI_ADDR_W),
      .AXI_DATA_W (AXI_DATA_W),
      .LEN_W      (LEN_W)
   ) splitter_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_addr_i (req_addr_i),
      .req_len_i  (req_len_i),
      .cmd        (cmd_if)
   );

   read_sequencer sequencer_i (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .req_valid_i     (req_valid_i),
      .req_ready_o     (req_ready_o),
      .cmd             (cmd_if),
      .aligner_empty_i (aligner_empty),
      .axi_arvalid_o   (axi_arvalid_o),
      .axi_arlen_o     (axi_arlen_o),
      .axi_arready_i   (axi_arready_i),
      .axi_rvalid_i    (axi_rvalid_i),
      .axi_rlast_i     (axi_rlast_i),
      .axi_rready_o    (axi_rready_o),
      .burst_done_o    (burst_done)
   );

   read_aligner #(
      .AXI_DATA_W (AXI_DATA_W),
      .LEN_W      (LEN_W)
   ) aligner_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .offset_i     (req_addr_i[OFF_W-1:0]),
      .len_i        (req_len_i),
      .start_i      (cmd_if.start),
      .beat_data_i  (axi_rdata_i),
      .beat_valid_i (rbeat_valid),
      .burst_done_i (burst_done),
      .rdata_o      (rdata_o),
      .rvalid_o     (rvalid_o),
      .rlast_o      (rlast_o),
      .empty_o      (aligner_empty)
   );

endmodule

// ==== verification/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic [ADDR_W-1:0] araddr_i,
   input  logic [7:0]        arlen_i,
   input  logic              arvalid_i,
   output logic              arready_o,
   output logic [DATA_W-1:0] rdata_o,
   output logic              rlast_o,
   output logic              rvalid_o,
   input  logic              rready_i
);
   localparam int BYTES = DATA_W / 8;

   logic [31:0]       rnd = 32'd44325;
   logic              ar_hs;        // Handshakes seen at the last rising edge
   logic              r_hs;
   logic [ADDR_W-1:0] ar_addr;
   logic [7:0]        ar_len;
   logic [ADDR_W-1:0] beat_addr;
   int                beats_left;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // Byte at address a is (a[7:0] ^ a[15:8]) + 0x5A
   function automatic logic [DATA_W-1:0] beat_data(input logic [ADDR_W-1:0] a);
      logic [DATA_W-1:0] d;
      logic [ADDR_W-1:0] b;
      for (int j = 0; j < BYTES; j++) begin
         b = a + ADDR_W'(j);
         d[8*j +: 8] = (b[7:0] ^ b[15:8]) + 8'h5A;
      end
      return d;
   endfunction

   initial begin
      arready_o = 1'b0;
      rvalid_o  = 1'b0;
      rlast_o   = 1'b0;
      rdata_o   = '0;
   end

   always @(posedge clk_i) begin
      ar_hs   <= arvalid_i && arready_o;
      r_hs    <= rvalid_o && rready_i;
      ar_addr <= araddr_i;
      ar_len  <= arlen_i;
   end

   // Outputs change on the falling edge only
   always @(negedge clk_i) begin
      rnd = xorshift32(rnd);
      if (rst_i) begin
         arready_o  <= 1'b0;
         rvalid_o   <= 1'b0;
         rlast_o    <= 1'b0;
         beats_left = 0;
      end else begin
         if (ar_hs) begin
            beat_addr  = ar_addr;
            beats_left = int'(ar_len) + 1;
         end
         if (r_hs) begin
            beat_addr  = beat_addr + ADDR_W'(BYTES);
            beats_left = beats_left - 1;
         end
         arready_o <= (beats_left == 0) && (rnd[1:0] != 2'b00);
         if (rvalid_o && !r_hs) begin
            rvalid_o <= 1'b1;   // Beat held until accepted
         end else if ((beats_left > 0) && (rnd[3:2] != 2'b00)) begin
            rvalid_o <= 1'b1;
            rdata_o  <= beat_data(beat_addr);
            rlast_o  <= (beats_left == 1);
         end else begin
            rvalid_o <= 1'b0;
            rlast_o  <= 1'b0;
         end
      end
   end

endmodule

// ==== verification/simple_axi_read_assert.sv ====
`timescale 1ns/1ps

module simple_axi_read_assert
   import axi_read_pkg::*;
#(
   parameter int AXI_ADDR_W = 32,
   parameter int AXI_DATA_W = 32
) (
   input logic                  clk_i,
   input logic                  rst_i,
   input logic [AXI_ADDR_W-1:0] araddr_i,
   input logic [AXI_LEN_W-1:0]  arlen_i,
   input logic                  arvalid_i,
   input logic                  arready_i,
   input logic                  rready_i,
   input logic                  rvalid_i,
   input logic                  aligner_empty_i
);
   localparam int OFF_W = offset_w(AXI_DATA_W);
   localparam int END_W = BOUNDARY_W + 2;

   int               assert_errors = 0;
   logic [END_W-1:0] burst_end;   // One past the last byte, page relative

   assign burst_end = END_W'(araddr_i[BOUNDARY_W-1:0])
                      + ((END_W'(arlen_i) + 1'b1) << OFF_W);

   ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
      else begin
         assert_errors++;
         $error("AR request dropped or moved before arready");
      end

   page_cross: assert property (@(posedge clk_i) disable iff (rst_i)
      arvalid_i |-> burst_end <= END_W'(1 << BOUNDARY_W))
      else begin
         assert_errors++;
         $error("Burst at %h crosses a 4 KB boundary", araddr_i);
      end

   // Output word needs R activity or owed words one cycle earlier
   stream_idle: assert property (@(posedge clk_i) disable iff (rst_i)
      rvalid_i |-> $past(rready_i || !aligner_empty_i))
      else begin
         assert_errors++;
         $error("Output word while R was idle and the aligner was empty");
      end

endmodule

bind simple_axi_read simple_axi_read_assert #(
   .AXI_ADDR_W (AXI_ADDR_W),
   .AXI_DATA_W (AXI_DATA_W)
) assert_i (
   .clk_i           (clk_i),
   .rst_i           (rst_i),
   .araddr_i        (axi_araddr_o),
   .arlen_i         (axi_arlen_o),
   .arvalid_i       (axi_arvalid_o),
   .arready_i       (axi_arready_i),
   .rready_i        (axi_rready_o),
   .rvalid_i        (rvalid_o),
   .aligner_empty_i (aligner_empty)
);

// ==== verification/tb_simple_axi_read.sv ====
`timescale 1ns/1ps

module tb_simple_axi_read
   import axi_read_pkg::*;
();
   localparam int ADDR_W       = 32;
   localparam int DATA_W       = 32;
   localparam int LEN_W        = 12;
   localparam int BYTES        = DATA_W / 8;
   localparam int N_RANDOM     = 30;
   localparam int MAX_RAND_LEN = 600;
   localparam int PAGE_BYTES   = 4096;   // AXI bursts stay inside one page
   localparam int BURST_MAX    = 256;
   localparam logic [2:0] EXP_ARSIZE  = 3'($clog2(BYTES));   // log2 of bytes per beat
   localparam logic [1:0] EXP_ARBURST = 2'b01;     // INCR
   localparam logic [3:0] EXP_ARCACHE = 4'b0010;   // Modifiable, non-bufferable
   localparam logic [2:0] EXP_ARPROT  = 3'b010;    // Non-secure data
   // Beat bound over all tests, one spare beat per request
   localparam longint TOTAL_BEATS  = 17 + 9 * 6 + 11 + 301
                                     + N_RANDOM * (MAX_RAND_LEN / BYTES + 2);
   localparam longint STALL_FACTOR = 20;   // Worst-case cycles per beat
   localparam longint WATCHDOG_NS  = (TOTAL_BEATS * STALL_FACTOR + 16) * 8;

   logic                 clk_i;
   logic                 rst_i;
   logic                 req_valid_i;
   logic                 req_ready_o;
   logic [ADDR_W-1:0]    req_addr_i;
   logic [LEN_W-1:0]     req_len_i;
   logic [DATA_W-1:0]    rdata_o;
   logic                 rvalid_o;
   logic                 rlast_o;
   logic [ADDR_W-1:0]    axi_araddr_o;
   logic [AXI_LEN_W-1:0] axi_arlen_o;
   logic [2:0]           axi_arsize_o;
   logic [1:0]           axi_arburst_o;
   logic [3:0]           axi_arcache_o;
   logic [2:0]           axi_arprot_o;
   logic                 axi_arvalid_o;
   logic                 axi_arready_i;
   logic [DATA_W-1:0]    axi_rdata_i;
   logic                 axi_rlast_i;
   logic                 axi_rvalid_i;
   logic                 axi_rready_o;

   int                   errors;
   int                   checks;
   int                   assert_fails;
   int                   lasts;          // rlast_o words seen
   logic [31:0]          rnd;
   logic [DATA_W-1:0]    word_q[$];
   logic                 last_q[$];
   logic [ADDR_W-1:0]    ar_addr_q[$];
   logic [AXI_LEN_W-1:0] ar_len_q[$];

   simple_axi_read #(
      .AXI_ADDR_W (ADDR_W),
      .AXI_DATA_W (DATA_W),
      .LEN_W      (LEN_W)
   ) dut_i (.*);

   axi_mem_model #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) mem_i (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .araddr_i  (axi_araddr_o),
      .arlen_i   (axi_arlen_o),
      .arvalid_i (axi_arvalid_o),
      .arready_o (axi_arready_i),
      .rdata_o   (axi_rdata_i),
      .rlast_o   (axi_rlast_i),
      .rvalid_o  (axi_rvalid_i),
      .rready_i  (axi_rready_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns with the DUT still busy", WATCHDOG_NS);
      $display("Test failed");
      $finish;
   end

   // Output words and AR handshakes
   always @(posedge clk_i) begin
      if (rvalid_o) begin
         word_q.push_back(rdata_o);
         last_q.push_back(rlast_o);
         if (rlast_o) lasts++;
      end
      if (axi_arvalid_o && axi_arready_i) begin
         ar_addr_q.push_back(axi_araddr_o);
         ar_len_q.push_back(axi_arlen_o);
         check_ar_attr(axi_arsize_o, axi_arburst_o, axi_arcache_o, axi_arprot_o);
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] base);
      logic [DATA_W-1:0] w;
      logic [ADDR_W-1:0] a;
      for (int j = 0; j < BYTES; j++) begin
         a = base + ADDR_W'(j);
         w[8*j +: 8] = (a[7:0] ^ a[15:8]) + 8'h5A;
      end
      return w;
   endfunction

   task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input int nbytes);
      checks++;
      for (int j = 0; j < nbytes; j++) begin
         if (got[8*j +: 8] !== exp[8*j +: 8]) begin
            errors++;
            $display("[FAIL] %0t rdata_o got %h expected %h (%0d bytes valid)",
                     $time, got, exp, nbytes);
            return;
         end
      end
   endtask

   task automatic check_ar(input logic [ADDR_W-1:0] got_addr,
                           input logic [AXI_LEN_W-1:0] got_len,
                           input logic [ADDR_W-1:0] exp_addr,
                           input logic [AXI_LEN_W-1:0] exp_len);
      checks++;
      if ((got_addr !== exp_addr) || (got_len !== exp_len)) begin
         errors++;
         $display("[FAIL] %0t axi_araddr_o/axi_arlen_o got %h/%0d expected %h/%0d",
                  $time, got_addr, got_len, exp_addr, exp_len);
      end
   endtask

   // Fixed AR attributes of every burst
   task automatic check_ar_attr(input logic [2:0] got_size, input logic [1:0] got_burst,
                                input logic [3:0] got_cache, input logic [2:0] got_prot);
      checks++;
      if ({got_size, got_burst, got_cache, got_prot}
          !== {EXP_ARSIZE, EXP_ARBURST, EXP_ARCACHE, EXP_ARPROT}) begin
         errors++;
         $display("[FAIL] %0t axi_arsize_o/axi_arburst_o/axi_arcache_o/axi_arprot_o %s",
                  $time, $sformatf("got %h/%h/%h/%h expected %h/%h/%h/%h",
                  got_size, got_burst, got_cache, got_prot,
                  EXP_ARSIZE, EXP_ARBURST, EXP_ARCACHE, EXP_ARPROT));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // Bursts must stop at 4 KB pages and at 256 beats
   task automatic check_bursts(input logic [ADDR_W-1:0] addr, input int len);
      logic [ADDR_W-1:0] beat_addr;
      int                beats_left;
      int                page_left;
      int                n;
      beat_addr  = addr & ~ADDR_W'(BYTES - 1);
      beats_left = (int'(addr % BYTES) + len + BYTES - 1) / BYTES;
      while (beats_left > 0) begin
         page_left = (PAGE_BYTES - int'(beat_addr % PAGE_BYTES)) / BYTES;
         n = beats_left;
         if (page_left < n) n = page_left;
         if (BURST_MAX < n) n = BURST_MAX;
         if (ar_addr_q.size() == 0) begin
            errors++;
            $display("Burst at %h never appeared on the AR channel", beat_addr);
         end else begin
            check_ar(ar_addr_q.pop_front(), ar_len_q.pop_front(), beat_addr,
                     AXI_LEN_W'(n - 1));
         end
         beat_addr  = beat_addr + ADDR_W'(n * BYTES);
         beats_left = beats_left - n;
      end
      if (ar_addr_q.size() != 0) begin
         errors++;
         $display("%0d more bursts issued than the request needs", ar_addr_q.size());
      end
      ar_addr_q.delete();
      ar_len_q.delete();
   endtask

   // Entered on a falling edge
   task automatic run_request(input logic [ADDR_W-1:0] addr, input int len);
      int words;
      int valid_bytes;
      words = (len + BYTES - 1) / BYTES;
      while (!req_ready_o) @(negedge clk_i);
      req_valid_i = 1'b1;
      req_addr_i  = addr;
      req_len_i   = LEN_W'(len);
      @(negedge clk_i);
      req_valid_i = 1'b0;
      while (lasts == 0) @(negedge clk_i);
      if (word_q.size() != words) begin
         errors++;
         $display("Request at %h of %0d bytes gave %0d words instead of %0d",
                  addr, len, word_q.size(), words);
      end
      for (int k = 0; (k < words) && (word_q.size() > 0); k++) begin
         valid_bytes = (len - k * BYTES < BYTES) ? len - k * BYTES : BYTES;
         check_word(word_q.pop_front(), expected_word(addr + ADDR_W'(k * BYTES)),
                    valid_bytes);
         check_flag("rlast_o", last_q.pop_front(), k == words - 1);
      end
      word_q.delete();
      last_q.delete();
      lasts = 0;
      check_bursts(addr, len);
   endtask

   task automatic test_reset_aligned();
      check_flag("req_ready_o", req_ready_o, 1'b1);
      check_flag("axi_arvalid_o", axi_arvalid_o, 1'b0);
      check_flag("axi_rready_o", axi_rready_o, 1'b0);
      check_flag("rvalid_o", rvalid_o, 1'b0);
      check_flag("rlast_o", rlast_o, 1'b0);
      run_request(32'h100, 64);
   endtask

   task automatic test_unaligned();
      int lens[3] = '{1, 5, 13};
      for (int off = 1; off <= 3; off++) begin
         foreach (lens[i]) begin
            run_request(32'h2000 + ADDR_W'(256 * i + 64 * off + off), lens[i]);
         end
      end
   endtask

   task automatic test_page_split();
      run_request(32'hFF0, 40);
   endtask

   task automatic test_long();
      run_request(32'h8000, 1200);
   endtask

   task automatic test_random();
      logic [ADDR_W-1:0] addr;
      int                len;
      for (int n = 0; n < N_RANDOM; n++) begin
         rnd  = xorshift32(rnd);
         addr = ADDR_W'(rnd[15:0]);   // Often lands near a page edge
         rnd  = xorshift32(rnd);
         len  = int'(rnd % 32'(MAX_RAND_LEN)) + 1;
         run_request(addr, len);
      end
   endtask

   initial begin
      rst_i       = 1'b1;
      req_valid_i = 1'b0;
      req_addr_i  = '0;
      req_len_i   = '0;
      errors      = 0;
      checks      = 0;
      lasts       = 0;
      rnd         = 32'd44325;
      repeat (16) @(negedge clk_i);
      rst_i = 1'b0;
      test_reset_aligned();
      test_unaligned();
      test_page_split();
      test_long();
      test_random();
      assert_fails = dut_i.assert_i.assert_errors;
      $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
               checks, errors, assert_fails);
      if ((errors == 0) && (assert_fails == 0)) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== project.f ====
common/axi_read_pkg.sv
common/burst_cmd_if.sv
simple_axi_read/burst_splitter.sv
simple_axi_read/read_sequencer.sv
simple_axi_read/read_aligner.sv
simple_axi_read/simple_axi_read.sv
verification/axi_mem_model.sv
verification/simple_axi_read_assert.sv
verification/tb_simple_axi_read.sv

// ==== Makefile ====
BIN  := obj_dir/Vtb_simple_axi_read
SRCS := $(shell cat project.f)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "^Test completed successfully$$"

$(BIN): project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_simple_axi_read -f project.f

clean:
	rm -rf obj_dir
